// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_top
RTL_TOP    = hsid_vctr_top
FLIST      = list.f
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// File: hsid_cfg_pkg.sv
package hsid_cfg_pkg;

  // Sample format of the hyperspectral pipeline
  localparam int hsid_word_w = 16;  // Bits per band sample

  // Band set geometry
  localparam int hsid_band_aw = 3;  // FIFO address bits
  localparam int hsid_bands   = 8;  // Bands per vector

  // One band sample, or the sum of two samples
  typedef logic [hsid_word_w-1:0] hsid_word_t;

  // Holds 0..hsid_bands, hence one bit wider than the address
  typedef logic [hsid_band_aw:0] band_cnt_t;

  // Read and write pointers into a band FIFO
  typedef logic [hsid_band_aw-1:0] band_ptr_t;

endpackage

// File: hsid_ctrl_pkg.sv
package hsid_ctrl_pkg;

  // Phases of one vector operation
  typedef enum logic [1:0] {
    idle,       // Waiting for start
    reading,    // Loading both input vectors
    operation,  // Pop, add and write back
    done        // Sums waiting for the host
  } vctr_state_t;

  // Level status seen by the host
  typedef struct packed {
    logic idle;   // Unit can take a start
    logic ready;  // Input words are accepted
    logic done;   // Sums can be popped
  } vctr_status_t;

  // Occupancy flags of a band FIFO
  typedef struct packed {
    logic full;
    logic empty;
  } fifo_flags_t;

endpackage

// File: hsid_fifo.sv
`timescale 1ns/1ps

module hsid_fifo
  import hsid_cfg_pkg::*;
  import hsid_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_en,     // Push data_in
  input  logic        rd_en,     // Pop the head word
  input  hsid_word_t  data_in,
  output hsid_word_t  data_out,  // Head word, valid while not empty
  output fifo_flags_t flags,
  output band_cnt_t   count      // Words currently stored
);

  hsid_word_t mem [hsid_bands];  // Band storage

  band_ptr_t wr_ptr;  // Next slot to write
  band_ptr_t rd_ptr;  // Slot of the head word

  logic do_wr;
  logic do_rd;

  // Full and empty come straight from the occupancy count
  assign flags.full  = (count == band_cnt_t'(hsid_bands));
  assign flags.empty = (count == '0);

  // A push into a full FIFO is dropped, even with a pop in the same cycle
  assign do_wr = wr_en && !flags.full;
  assign do_rd = rd_en && !flags.empty;  // Pop on empty ignored

  // Storage array
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Show-ahead read port
  assign data_out = mem[rd_ptr];

  // Write pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_wr) begin
      wr_ptr <= wr_ptr + band_ptr_t'(1);  // Wraps at the depth
    end
  end

  // Read pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_rd) begin
      rd_ptr <= rd_ptr + band_ptr_t'(1);
    end
  end

  // Occupancy counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({do_wr, do_rd})
        2'b10: begin
          count <= count + band_cnt_t'(1);  // Push only
        end
        2'b01: begin
          count <= count - band_cnt_t'(1);  // Pop only
        end
        default: begin
          count <= count;  // Both or neither
        end
      endcase
    end
  end

endmodule

// File: hsid_vctr_top.sv
`timescale 1ns/1ps

module hsid_vctr_top
  import hsid_cfg_pkg::*;
  import hsid_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  input  logic         data_in_en,
  input  logic         data_out_en,
  input  hsid_word_t   data_in,      // Band samples, first vector then second
  output hsid_word_t   data_out,     // Sum vector toward the host
  output vctr_status_t status
);

  // Attachment point for the rest of the image pipeline
  hsid_word_t   add_data_out;
  vctr_status_t add_status;

  vctr_add_unit u_add (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .data_in_en  (data_in_en),
    .data_out_en (data_out_en),
    .data_in     (data_in),
    .data_out    (add_data_out),
    .status      (add_status)
  );

  assign data_out = add_data_out;
  assign status   = add_status;

endmodule

// File: list.f
hsid_cfg_pkg.sv
hsid_ctrl_pkg.sv
hsid_fifo.sv
vctr_add_unit.sv
hsid_vctr_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import hsid_cfg_pkg::*;
  import hsid_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         data_in_en,
  input  hsid_word_t   data_in,
  input  logic         data_out_en,
  input  hsid_word_t   data_out,
  input  vctr_status_t status,
  input  int           exp_accept,  // Words one test should load
  input  int           exp_pops,    // Sums one test should return
  input  logic         run_done,    // Raised once after the last test
  output int           err_cnt,
  output int           tests_done
);

  localparam vctr_status_t idle_status = '{idle: 1'b1, ready: 1'b0, done: 1'b0};

  hsid_word_t   in_q [$];            // Accepted words, first vector then second
  int           errors      = 0;
  int           test_err    = 0;
  int           pop_cnt     = 0;
  int           test_cnt    = 0;
  int           pass_cnt    = 0;
  logic         rst_seen    = 1'b0;
  vctr_status_t prev_status = '0;
  logic         prev_pop    = 1'b0;
  hsid_word_t   prev_out    = '0;

  assign err_cnt    = errors;
  assign tests_done = test_cnt;

  task automatic count_error();
    errors++;
    test_err++;
  endtask

  task automatic close_test();
    test_cnt++;
    if (test_err == 0) begin
      pass_cnt++;
      $display("Test %0d passed: %0d words in, %0d sums out", test_cnt, in_q.size(), pop_cnt);
    end else begin
      $display("Test %0d FAILED with %0d errors", test_cnt, test_err);
    end
    in_q.delete();
    pop_cnt  = 0;
    test_err = 0;
  endtask

  task automatic check_pop();
    hsid_word_t exp_sum;
    int         half;
    half = exp_accept / 2;
    if (pop_cnt + half >= in_q.size()) begin
      $display("Pop %0d of test %0d has no input pair to compare with", pop_cnt + 1,
               test_cnt + 1);
      count_error();
    end else begin
      exp_sum = in_q[pop_cnt] + in_q[pop_cnt + half];  // Wraps at 16 bits
      if (data_out !== exp_sum) begin
        $display("** Error: data_out at pop %0d of test %0d: expected %h, got %h",
                 pop_cnt + 1, test_cnt + 1, exp_sum, data_out);
        count_error();
      end
    end
    pop_cnt++;
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (!rst_seen) begin
        rst_seen = 1'b1;
        if (status !== idle_status) begin
          $display("** Error: status after reset: expected %h, got %h", idle_status, status);
          count_error();
        end
      end
      if (data_in_en && status.ready) begin
        if (in_q.size() >= exp_accept) begin
          $display("Test %0d took word %h beyond the %0d expected", test_cnt + 1, data_in,
                   exp_accept);
          count_error();
        end
        in_q.push_back(data_in);
      end
      if (prev_status.ready && !status.ready && in_q.size() != exp_accept) begin
        $display("Test %0d: ready fell after %0d words instead of %0d", test_cnt + 1,
                 in_q.size(), exp_accept);
        count_error();
      end
      if (status.done && !prev_status.done && prev_status !== vctr_status_t'('0)) begin
        $display("** Error: status before done: expected %h, got %h", vctr_status_t'('0),
                 prev_status);
        count_error();
      end
      if (status.done && prev_status.done && !prev_pop && data_out !== prev_out) begin
        $display("** Error: data_out during stall: expected %h, got %h", prev_out, data_out);
        count_error();
      end
      if (data_out_en && status.done) begin
        check_pop();
      end
      if (prev_status.done && !status.done) begin
        if (pop_cnt != exp_pops) begin
          $display("Test %0d: done fell after %0d pops instead of %0d", test_cnt + 1,
                   pop_cnt, exp_pops);
          count_error();
        end
        if (status !== idle_status) begin
          $display("** Error: status after last pop: expected %h, got %h", idle_status,
                   status);
          count_error();
        end
        close_test();
      end
      prev_status = status;
      prev_pop    = data_out_en && status.done;
      prev_out    = data_out;
    end
  end

  always @(posedge run_done) begin
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", test_cnt, pass_cnt,
             test_cnt - pass_cnt, errors);
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;  // 100 ns period
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;  // Released just after an edge
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top
  import hsid_cfg_pkg::*;
  import hsid_ctrl_pkg::*;
();

  localparam int reset_cycles   = 16;
  localparam int n_rows         = 6;
  localparam int timeout_cycles = n_rows * 200 + reset_cycles;

  typedef enum logic [1:0] {
    vec_ramp,
    vec_rand,
    vec_ovf   // Sums pass 16 bits
  } vec_mode_t;

  typedef struct packed {
    vec_mode_t mode;
    int        gap_max;      // Idle cycles before each input word, 0..gap_max
    int        stall_max;    // Idle cycles before each pop, 0..stall_max
    logic      stray_start;  // Extra start pulse during operation
    int        exp_accept;
    int        exp_pops;
  } test_row_t;

  logic         clk;
  logic         rst_n;
  logic         start;
  logic         data_in_en;
  logic         data_out_en;
  hsid_word_t   data_in;
  hsid_word_t   data_out;
  vctr_status_t status;
  int           exp_accept;
  int           exp_pops;
  logic         run_done;
  int           err_cnt;
  int           tests_done;
  int           cycle_cnt = 0;
  test_row_t    rows [n_rows];

  tb_clk_gen #(.reset_cycles(reset_cycles)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  hsid_vctr_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .data_in_en  (data_in_en),
    .data_out_en (data_out_en),
    .data_in     (data_in),
    .data_out    (data_out),
    .status      (status)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .data_in_en  (data_in_en),
    .data_in     (data_in),
    .data_out_en (data_out_en),
    .data_out    (data_out),
    .status      (status),
    .exp_accept  (exp_accept),
    .exp_pops    (exp_pops),
    .run_done    (run_done),
    .err_cnt     (err_cnt),
    .tests_done  (tests_done)
  );

  task automatic wait_cycle();
    @(posedge clk);
    #1;  // Drive slot after the edge
  endtask

  function automatic int pick_delay(input int max_cycles);
    if (max_cycles == 0) begin
      return 0;
    end
    return int'($urandom % (max_cycles + 1));
  endfunction

  function automatic hsid_word_t make_word(input vec_mode_t mode, input int t, input int idx);
    hsid_word_t w;
    case (mode)
      vec_ramp: begin
        w = hsid_word_t'(t * 256 + idx * 17 + 1);
      end
      vec_rand: begin
        w = hsid_word_t'($urandom);
      end
      default: begin
        if (idx < hsid_bands) begin
          w = hsid_word_t'(32'hff00 + idx * 16);
        end else begin
          w = hsid_word_t'(32'h0180 + idx);
        end
      end
    endcase
    return w;
  endfunction

  task automatic run_test(input int t);
    test_row_t row;
    row        = rows[t];
    exp_accept = row.exp_accept;
    exp_pops   = row.exp_pops;
    while (!status.idle) wait_cycle();
    start = 1'b1;
    wait_cycle();
    start = 1'b0;
    while (!status.ready) wait_cycle();
    for (int i = 0; i < row.exp_accept; i++) begin
      repeat (pick_delay(row.gap_max)) wait_cycle();
      data_in_en = 1'b1;
      data_in    = make_word(row.mode, t, i);
      wait_cycle();
      data_in_en = 1'b0;
    end
    data_in_en = 1'b1;  // One word too many, must be refused
    data_in    = ~data_in;
    wait_cycle();
    data_in_en = 1'b0;
    if (row.stray_start) begin
      start = 1'b1;
      wait_cycle();
      start = 1'b0;
    end
    while (!status.done) wait_cycle();
    for (int k = 0; k < row.exp_pops; k++) begin
      repeat (pick_delay(row.stall_max)) wait_cycle();
      data_out_en = 1'b1;
      wait_cycle();
      data_out_en = 1'b0;
    end
    while (!status.idle) wait_cycle();
    wait_cycle();  // Lets the checker close the test
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int unsigned seed;
    start       = 1'b0;
    data_in_en  = 1'b0;
    data_out_en = 1'b0;
    data_in     = '0;
    exp_accept  = 0;
    exp_pops    = 0;
    run_done    = 1'b0;
    seed        = 32'h0faf_7f71;
    void'($urandom(seed));
    rows[0] = '{vec_ramp, 0, 0, 1'b0, 16, 8};
    rows[1] = '{vec_ramp, 2, 0, 1'b1, 16, 8};
    rows[2] = '{vec_rand, 0, 3, 1'b0, 16, 8};
    rows[3] = '{vec_rand, 3, 3, 1'b1, 16, 8};
    rows[4] = '{vec_ovf,  1, 2, 1'b0, 16, 8};
    rows[5] = '{vec_ovf,  0, 0, 1'b1, 16, 8};
    @(posedge rst_n);
    wait_cycle();
    for (int t = 0; t < n_rows; t++) begin
      run_test(t);
    end
    run_done = 1'b1;
    #1;
    if (err_cnt == 0 && tests_done == n_rows) begin
      $display("Simulation completed successfully");
    end else begin
      if (tests_done != n_rows) begin
        $display("Only %0d of %0d tests reached their end", tests_done, n_rows);
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vctr_add_unit.sv
`timescale 1ns/1ps

module vctr_add_unit
  import hsid_cfg_pkg::*;
  import hsid_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,        // Begin a vector, taken in idle only
  input  logic         data_in_en,   // Offer data_in while ready
  input  logic         data_out_en,  // Pop one sum while done
  input  hsid_word_t   data_in,
  output hsid_word_t   data_out,     // Current sum
  output vctr_status_t status
);

  vctr_state_t state;
  vctr_state_t next_state;

  // Band FIFO interfaces
  fifo_flags_t flags_in_1;
  fifo_flags_t flags_in_2;
  fifo_flags_t flags_out;
  band_cnt_t   cnt_in_2;
  band_cnt_t   cnt_out;
  hsid_word_t  head_in_1;
  hsid_word_t  head_in_2;

  logic wr_in_1;
  logic wr_in_2;
  logic rd_out;
  logic last_load;  // This push fills the second FIFO

  // Add pipeline
  logic       pop_pair;     // Stage 1 takes a pair this cycle
  logic       s1_vld;
  hsid_word_t s1_a;
  hsid_word_t s1_b;
  logic       s2_vld;       // Drives the output FIFO write
  hsid_word_t s2_sum;
  band_cnt_t  out_pending;  // Stored sums plus pairs in flight
  band_cnt_t  sum_cnt;      // Sums written for this vector

  // Loading: the first FIFO fills, then the second
  assign wr_in_1   = (state == reading) && data_in_en && !flags_in_1.full;
  assign wr_in_2   = (state == reading) && data_in_en && flags_in_1.full && !flags_in_2.full;
  assign last_load = wr_in_2 && (cnt_in_2 == band_cnt_t'(hsid_bands - 1));

  // Reserve room in the output FIFO for everything in flight
  assign out_pending = cnt_out + band_cnt_t'(s1_vld) + band_cnt_t'(s2_vld);
  assign pop_pair    = (state == operation) && !flags_in_1.empty && !flags_in_2.empty &&
                       (out_pending < band_cnt_t'(hsid_bands));

  // Host pops only in done
  assign rd_out = (state == done) && data_out_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (start) begin
          next_state = reading;
        end
      end
      reading: begin
        if (last_load) begin
          next_state = operation;  // Sixteenth word taken
        end
      end
      operation: begin
        if (sum_cnt == band_cnt_t'(hsid_bands)) begin
          next_state = done;  // Every sum is in the output FIFO
        end
      end
      done: begin
        if (flags_out.empty) begin
          next_state = idle;
        end
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // Pipeline valid bits and sum counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld  <= 1'b0;
      s2_vld  <= 1'b0;
      sum_cnt <= '0;
    end else begin
      s1_vld <= pop_pair;
      s2_vld <= s1_vld;
      if (state == idle) begin
        sum_cnt <= '0;  // Fresh count per vector
      end else if (s2_vld) begin
        sum_cnt <= sum_cnt + band_cnt_t'(1);
      end
    end
  end

  // Pipeline payload
  always_ff @(posedge clk) begin
    if (pop_pair) begin
      s1_a <= head_in_1;
      s1_b <= head_in_2;
    end
    if (s1_vld) begin
      s2_sum <= s1_a + s1_b;  // Wraps modulo 2^16
    end
  end

  // Status follows the state directly
  assign status.idle  = (state == idle);
  assign status.ready = (state == reading);
  assign status.done  = (state == done);

  hsid_fifo band_in_1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_in_1),
    .rd_en    (pop_pair),
    .data_in  (data_in),
    .data_out (head_in_1),
    .flags    (flags_in_1),
    .count    ()
  );

  hsid_fifo band_in_2 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_in_2),
    .rd_en    (pop_pair),
    .data_in  (data_in),
    .data_out (head_in_2),
    .flags    (flags_in_2),
    .count    (cnt_in_2)
  );

  hsid_fifo band_out (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (s2_vld),
    .rd_en    (rd_out),
    .data_in  (s2_sum),
    .data_out (data_out),
    .flags    (flags_out),
    .count    (cnt_out)
  );

endmodule
